/* design/ipod_pkg.sv */
package ipod_pkg;

  // ====================
  // Widths
  // ====================
  localparam int flash_addr_w = 23;
  localparam int flash_data_w = 32;
  localparam int sample_w     = 16;
  localparam int rate_w       = 16;

  // Top of the sample area, in words
  localparam logic [flash_addr_w-1:0] last_word = 23'h7FFFF;

  // ====================
  // Playback rate
  // ====================
  localparam logic [rate_w-1:0] rate_default = 16'd1136;  // About 44 kHz at 50 MHz
  localparam logic [rate_w-1:0] rate_step    = 16'd32;
  localparam logic [rate_w-1:0] rate_min     = 16'd64;
  localparam logic [rate_w-1:0] rate_max     = 16'd4096;

  // ====================
  // Command characters
  // ====================
  localparam logic [7:0] char_play     = 8'h45;  // E
  localparam logic [7:0] char_pause    = 8'h44;  // D
  localparam logic [7:0] char_forward  = 8'h46;  // F
  localparam logic [7:0] char_backward = 8'h42;  // B
  localparam logic [7:0] char_restart  = 8'h52;  // R

  // Reader to flash
  typedef struct packed {
    logic                    read;
    logic [flash_addr_w-1:0] address;
  } flash_req_t;

  // Flash to reader
  typedef struct packed {
    logic                    waitrequest;
    logic                    readdatavalid;
    logic [flash_data_w-1:0] readdata;
  } flash_rsp_t;

  // Player state from the key decoder
  typedef struct packed {
    logic playing;
    logic forward;
    logic restart;  // One-cycle strobe
  } player_ctrl_t;

endpackage

/* design/key_command_decoder.sv */
`timescale 1ns/1ps

module key_command_decoder (
  input  logic                  CLK_50M,
  input  logic                  rst,
  input  logic [7:0]            kbd_ascii,
  input  logic                  kbd_valid,
  output ipod_pkg::player_ctrl_t ctrl
);

  ipod_pkg::player_ctrl_t ctrl_q;

  assign ctrl = ctrl_q;

  // Command bytes land in the control register on the next edge
  always_ff @(posedge CLK_50M)
  begin
    if (rst)
    begin
      ctrl_q.playing <= 1'b0;  // Paused
      ctrl_q.forward <= 1'b1;
      ctrl_q.restart <= 1'b0;
    end
    else
    begin
      ctrl_q.restart <= 1'b0;  // Strobe lasts one cycle
      if (kbd_valid)
      begin
        case (kbd_ascii)
          ipod_pkg::char_play:
          begin
            ctrl_q.playing <= 1'b1;
          end
          ipod_pkg::char_pause:
          begin
            ctrl_q.playing <= 1'b0;
          end
          ipod_pkg::char_forward:
          begin
            ctrl_q.forward <= 1'b1;
          end
          ipod_pkg::char_backward:
          begin
            ctrl_q.forward <= 1'b0;
          end
          ipod_pkg::char_restart:
          begin
            ctrl_q.restart <= 1'b1;
          end
          default:
          begin
            // Anything else is ignored
          end
        endcase
      end
    end
  end

endmodule

/* design/rate_controller.sv */
`timescale 1ns/1ps

module rate_controller (
  input  logic                        CLK_50M,
  input  logic                        rst,
  input  logic                        speed_up,
  input  logic                        speed_down,
  input  logic                        speed_reset,
  input  logic                        run,
  input  logic                        resync,
  output logic [ipod_pkg::rate_w-1:0] rate_count,
  output logic                        tick
);

  logic [ipod_pkg::rate_w-1:0] period;
  logic [ipod_pkg::rate_w-1:0] cnt;
  logic [ipod_pkg::rate_w:0]   sum_up;    // One extra bit for the add
  logic [ipod_pkg::rate_w:0]   floor_up;

  assign rate_count = period;
  assign sum_up     = {1'b0, period} + {1'b0, ipod_pkg::rate_step};
  assign floor_up   = {1'b0, ipod_pkg::rate_min} + {1'b0, ipod_pkg::rate_step};

  // ====================
  // Period register
  // ====================
  always_ff @(posedge CLK_50M)
  begin
    if (rst)
    begin
      period <= ipod_pkg::rate_default;
    end
    else if (speed_reset)
    begin
      period <= ipod_pkg::rate_default;
    end
    else if (speed_up)
    begin
      // Faster means a shorter period
      if ({1'b0, period} <= floor_up)
        period <= ipod_pkg::rate_min;
      else
        period <= period - ipod_pkg::rate_step;
    end
    else if (speed_down)
    begin
      if (sum_up >= {1'b0, ipod_pkg::rate_max})
        period <= ipod_pkg::rate_max;
      else
        period <= sum_up[ipod_pkg::rate_w-1:0];
    end
  end

  // ====================
  // Tick counter
  // ====================
  always_ff @(posedge CLK_50M)
  begin
    if (rst)
    begin
      cnt  <= '0;
      tick <= 1'b0;
    end
    else if (!run || resync)
    begin
      cnt  <= '0;  // Next tick one full period away
      tick <= 1'b0;
    end
    else if (cnt >= period - 1'b1)  // Also catches a period that just shrank
    begin
      cnt  <= '0;
      tick <= 1'b1;
    end
    else
    begin
      cnt  <= cnt + 1'b1;
      tick <= 1'b0;
    end
  end

endmodule

/* design/flash_word_reader.sv */
`timescale 1ns/1ps

module flash_word_reader (
  input  logic                              CLK_50M,
  input  logic                              rst,
  input  logic                              fetch,
  input  logic [ipod_pkg::flash_addr_w-1:0] fetch_addr,
  output logic                              busy,
  output logic                              word_valid,
  output logic [ipod_pkg::flash_data_w-1:0] word,
  output ipod_pkg::flash_req_t              flash_req,
  input  ipod_pkg::flash_rsp_t              flash_rsp
);

  typedef enum logic [1:0] {
    st_idle,
    st_req,   // read high until waitrequest drops
    st_wait   // accepted, waiting for readdatavalid
  } state_t;

  state_t                            state;
  logic [ipod_pkg::flash_addr_w-1:0] addr_q;

  assign busy = (state != st_idle);

  always_comb
  begin
    flash_req.read    = (state == st_req);
    flash_req.address = addr_q;  // Stable for the whole request
  end

  always_ff @(posedge CLK_50M)
  begin
    if (rst)
    begin
      state      <= st_idle;
      word_valid <= 1'b0;
    end
    else
    begin
      word_valid <= 1'b0;
      case (state)
        st_idle:
        begin
          if (fetch)
            state <= st_req;
        end
        st_req:
        begin
          if (!flash_rsp.waitrequest)
            state <= st_wait;  // Accepted, read drops next cycle
        end
        st_wait:
        begin
          if (flash_rsp.readdatavalid)
          begin
            word_valid <= 1'b1;
            state      <= st_idle;
          end
        end
        default: state <= st_idle;
      endcase
    end
  end

  // Address and data registers
  always_ff @(posedge CLK_50M)
  begin
    if (state == st_idle && fetch)
      addr_q <= fetch_addr;
    if (state == st_wait && flash_rsp.readdatavalid)
      word <= flash_rsp.readdata;
  end

endmodule

/* design/sample_sequencer.sv */
`timescale 1ns/1ps

module sample_sequencer (
  input  logic                                 CLK_50M,
  input  logic                                 rst,
  input  ipod_pkg::player_ctrl_t               ctrl,
  input  logic                                 tick,
  input  logic                                 word_valid,
  input  logic [ipod_pkg::flash_data_w-1:0]    word,
  input  logic                                 busy,
  output logic                                 fetch,
  output logic [ipod_pkg::flash_addr_w-1:0]    fetch_addr,
  output logic                                 run,
  output logic                                 resync,
  output logic signed [ipod_pkg::sample_w-1:0] sample,
  output logic                                 sample_valid
);

  logic [ipod_pkg::flash_addr_w-1:0] addr;
  logic [ipod_pkg::flash_addr_w-1:0] next_addr;
  logic [ipod_pkg::flash_data_w-1:0] word_q;
  logic                              loaded;
  logic                              half;        // 0 = first half of the word
  logic                              need_fetch;
  logic                              pending;     // Fetch issued, word not back yet
  logic                              stale;       // Word in flight belongs to an old address
  logic                              playing_q;
  logic                              take_high;

  assign fetch      = need_fetch && !pending && !busy;
  assign fetch_addr = addr;
  assign run        = ctrl.playing;
  assign resync     = ctrl.restart || (ctrl.playing && !playing_q);
  assign take_high  = ctrl.forward ? half : !half;

  // Step one word in the play direction, wrapping at both ends
  always_comb
  begin
    if (ctrl.forward)
      next_addr = (addr == ipod_pkg::last_word) ? '0 : addr + 1'b1;
    else
      next_addr = (addr == '0) ? ipod_pkg::last_word : addr - 1'b1;
  end

  // ====================
  // Control state
  // ====================
  always_ff @(posedge CLK_50M)
  begin
    if (rst)
    begin
      addr         <= '0;
      loaded       <= 1'b0;
      half         <= 1'b0;
      need_fetch   <= 1'b1;  // Word 0 goes out right after reset
      pending      <= 1'b0;
      stale        <= 1'b0;
      playing_q    <= 1'b0;
      sample_valid <= 1'b0;
    end
    else
    begin
      playing_q    <= ctrl.playing;
      sample_valid <= 1'b0;
      if (fetch)
      begin
        pending    <= 1'b1;
        need_fetch <= 1'b0;
      end
      if (word_valid)
      begin
        pending <= 1'b0;
        stale   <= 1'b0;
        if (!stale && !ctrl.restart)
          loaded <= 1'b1;
      end
      if (ctrl.restart)
      begin
        addr       <= ctrl.forward ? '0 : ipod_pkg::last_word;
        half       <= 1'b0;
        loaded     <= 1'b0;
        need_fetch <= 1'b1;
        stale      <= (pending && !word_valid) || fetch;  // Drop what is in flight
      end
      else if (tick && loaded)
      begin
        sample_valid <= 1'b1;
        half         <= !half;
        if (half)
        begin
          loaded     <= 1'b0;  // Both halves used
          addr       <= next_addr;
          need_fetch <= 1'b1;
        end
      end
    end
  end

  // Word and sample registers
  always_ff @(posedge CLK_50M)
  begin
    if (word_valid && !stale)
      word_q <= word;
    if (tick && loaded)
      sample <= take_high ? word_q[31:16] : word_q[15:0];
  end

endmodule

/* design/ipod_player_top.sv */
`timescale 1ns/1ps

module ipod_player_top (
  input  logic                                 CLK_50M,
  input  logic                                 rst,
  input  logic [7:0]                           kbd_ascii,
  input  logic                                 kbd_valid,
  input  logic                                 speed_up,
  input  logic                                 speed_down,
  input  logic                                 speed_reset,
  output ipod_pkg::flash_req_t                 flash_req,
  input  ipod_pkg::flash_rsp_t                 flash_rsp,
  output logic signed [ipod_pkg::sample_w-1:0] sample,
  output logic                                 sample_valid,
  output logic [ipod_pkg::rate_w-1:0]          rate_count,
  output ipod_pkg::player_ctrl_t               ctrl
);

  logic                              tick;
  logic                              run;
  logic                              resync;
  logic                              fetch;
  logic [ipod_pkg::flash_addr_w-1:0] fetch_addr;
  logic                              busy;
  logic                              word_valid;
  logic [ipod_pkg::flash_data_w-1:0] word;

  key_command_decoder decoder0 (
    .CLK_50M   (CLK_50M),
    .rst       (rst),
    .kbd_ascii (kbd_ascii),
    .kbd_valid (kbd_valid),
    .ctrl      (ctrl)
  );

  rate_controller rate0 (
    .CLK_50M     (CLK_50M),
    .rst         (rst),
    .speed_up    (speed_up),
    .speed_down  (speed_down),
    .speed_reset (speed_reset),
    .run         (run),
    .resync      (resync),
    .rate_count  (rate_count),
    .tick        (tick)
  );

  sample_sequencer seq0 (
    .CLK_50M      (CLK_50M),
    .rst          (rst),
    .ctrl         (ctrl),
    .tick         (tick),
    .word_valid   (word_valid),
    .word         (word),
    .busy         (busy),
    .fetch        (fetch),
    .fetch_addr   (fetch_addr),
    .run          (run),
    .resync       (resync),
    .sample       (sample),
    .sample_valid (sample_valid)
  );

  // Single flash port
  flash_word_reader reader0 (
    .CLK_50M    (CLK_50M),
    .rst        (rst),
    .fetch      (fetch),
    .fetch_addr (fetch_addr),
    .busy       (busy),
    .word_valid (word_valid),
    .word       (word),
    .flash_req  (flash_req),
    .flash_rsp  (flash_rsp)
  );

endmodule

/* tb/tb_clock_gen.sv */
`timescale 1ns/1ps

module tb_clock_gen (
  output logic CLK_50M,
  output logic rst
);

  // 50 MHz
  initial
  begin
    CLK_50M = 1'b0;
    forever #10 CLK_50M = ~CLK_50M;
  end

  initial
  begin
    rst = 1'b1;
    repeat (3) @(posedge CLK_50M);
    #2 rst = 1'b0;  // Released with the other inputs
  end

endmodule

/* tb/ipod_checker.sv */
`timescale 1ns/1ps

module ipod_checker (
  input  logic                          CLK_50M,
  input  logic                          rst,
  input  logic [7:0]                    kbd_ascii,
  input  logic                          kbd_valid,
  input  logic                          speed_up,
  input  logic                          speed_down,
  input  logic                          speed_reset,
  input  logic [ipod_pkg::sample_w-1:0] sample,
  input  logic                          sample_valid,
  input  logic [ipod_pkg::rate_w-1:0]   rate_count,
  input  ipod_pkg::flash_req_t          flash_req,
  input  ipod_pkg::flash_rsp_t          flash_rsp,
  output int                            sample_count,
  output int                            sample_errors,
  output int                            spacing_errors,
  output int                            rate_errors,
  output int                            protocol_errors
);

  logic [ipod_pkg::flash_addr_w-1:0] exp_addr;
  logic                              exp_half;       // 0 = first half of the word
  logic                              exp_fwd;
  logic                              key_due;        // Key reaches the sequencer one edge later
  logic [7:0]                        key_due_char;
  logic [ipod_pkg::rate_w-1:0]       exp_rate;
  logic [ipod_pkg::rate_w-1:0]       seen_rate;
  logic                              rate_due;
  logic                              spacing_known;
  logic [ipod_pkg::sample_w-1:0]     exp_value;
  logic                              prev_read;
  logic                              prev_wait;
  logic [ipod_pkg::flash_addr_w-1:0] prev_addr;
  longint                            cyc;
  longint                            last_cyc;
  int                                n_samples;
  int                                n_sample_err;
  int                                n_spacing_err;
  int                                n_rate_err;
  int                                n_proto_err;

  // ====================
  // Reference model
  // ====================

  // Flash image word is the inverted address above the address
  function automatic logic [ipod_pkg::sample_w-1:0] expected_sample(
    input logic [ipod_pkg::flash_addr_w-1:0] addr,
    input logic                              half,
    input logic                              fwd
  );
    logic [ipod_pkg::flash_data_w-1:0] w;
    logic                              high;
    begin
      w    = {~addr[15:0], addr[15:0]};
      high = fwd ? half : !half;  // Backward play starts with the high half
      return high ? w[31:16] : w[15:0];
    end
  endfunction

  function automatic logic [ipod_pkg::flash_addr_w-1:0] step_word(
    input logic [ipod_pkg::flash_addr_w-1:0] addr,
    input logic                              fwd
  );
    begin
      if (fwd)
        return (addr == ipod_pkg::last_word) ? '0 : addr + 1'b1;
      else
        return (addr == '0) ? ipod_pkg::last_word : addr - 1'b1;
    end
  endfunction

  function automatic logic [ipod_pkg::rate_w-1:0] next_rate(
    input logic [ipod_pkg::rate_w-1:0] r,
    input logic                        up,
    input logic                        down,
    input logic                        back_to_default
  );
    int v;
    begin
      v = int'(r);
      if (back_to_default)
        v = int'(ipod_pkg::rate_default);
      else if (up)
        v = v - int'(ipod_pkg::rate_step);
      else if (down)
        v = v + int'(ipod_pkg::rate_step);
      if (v < int'(ipod_pkg::rate_min))
        v = int'(ipod_pkg::rate_min);
      if (v > int'(ipod_pkg::rate_max))
        v = int'(ipod_pkg::rate_max);
      return v[ipod_pkg::rate_w-1:0];
    end
  endfunction

  // ====================
  // Compare process
  // ====================
  always @(posedge CLK_50M)
  begin
    if (rst)
    begin
      exp_addr      = '0;
      exp_half      = 1'b0;
      exp_fwd       = 1'b1;
      key_due       = 1'b0;
      key_due_char  = 8'h00;
      exp_rate      = ipod_pkg::rate_default;
      seen_rate     = ipod_pkg::rate_default;
      rate_due      = 1'b0;
      spacing_known = 1'b0;
      prev_read     = 1'b0;
      prev_wait     = 1'b0;
      prev_addr     = '0;
      cyc           = 0;
      last_cyc      = 0;
      n_samples     = 0;
      n_sample_err  = 0;
      n_spacing_err = 0;
      n_rate_err    = 0;
      n_proto_err   = 0;
    end
    else
    begin
      cyc = cyc + 1;

      // Read holds through waitrequest and drops once accepted
      if (prev_read)
      begin
        if (flash_req.read !== prev_wait)
        begin
          $display("[FAIL] t=%0t flash_req.read expected %0b got %0b",
                   $time, prev_wait, flash_req.read);
          n_proto_err = n_proto_err + 1;
        end
        if (prev_wait && flash_req.address !== prev_addr)
        begin
          $display("[FAIL] t=%0t flash_req.address expected %h got %h",
                   $time, prev_addr, flash_req.address);
          n_proto_err = n_proto_err + 1;
        end
      end
      prev_read = flash_req.read;
      prev_wait = flash_rsp.waitrequest;
      prev_addr = flash_req.address;

      if (rate_due || rate_count != seen_rate)
      begin
        if (rate_count !== exp_rate)
        begin
          $display("[FAIL] t=%0t rate_count expected %0d got %0d", $time, exp_rate, rate_count);
          n_rate_err = n_rate_err + 1;
        end
        seen_rate = rate_count;
        rate_due  = 1'b0;
      end
      if (sample_valid)
      begin
        exp_value = expected_sample(exp_addr, exp_half, exp_fwd);
        if (sample !== exp_value)
        begin
          $display("[FAIL] t=%0t sample expected %h got %h (word %h, half %0d)",
                   $time, exp_value, sample, exp_addr, exp_half);
          n_sample_err = n_sample_err + 1;
        end
        if (spacing_known && (cyc - last_cyc) != longint'(exp_rate))
        begin
          $display("[FAIL] t=%0t sample_valid spacing expected %0d got %0d",
                   $time, exp_rate, cyc - last_cyc);
          n_spacing_err = n_spacing_err + 1;
        end
        last_cyc      = cyc;
        spacing_known = 1'b1;
        n_samples     = n_samples + 1;
        if (exp_half)
          exp_addr = step_word(exp_addr, exp_fwd);
        exp_half = !exp_half;
      end
      if (key_due)
      begin
        if (key_due_char == ipod_pkg::char_forward)
          exp_fwd = 1'b1;
        else if (key_due_char == ipod_pkg::char_backward)
          exp_fwd = 1'b0;
        else if (key_due_char == ipod_pkg::char_restart)
        begin
          exp_addr = exp_fwd ? '0 : ipod_pkg::last_word;
          exp_half = 1'b0;
        end
        spacing_known = 1'b0;  // Restart starts a fresh period
        key_due       = 1'b0;
      end
      if (speed_up || speed_down || speed_reset)
      begin
        exp_rate      = next_rate(exp_rate, speed_up, speed_down, speed_reset);
        rate_due      = 1'b1;
        spacing_known = 1'b0;  // Interval across a change is irregular
      end
      if (kbd_valid)
      begin
        spacing_known = 1'b0;
        key_due       = 1'b1;
        key_due_char  = kbd_ascii;
      end
    end
    sample_count    <= n_samples;
    sample_errors   <= n_sample_err;
    spacing_errors  <= n_spacing_err;
    rate_errors     <= n_rate_err;
    protocol_errors <= n_proto_err;
  end

endmodule

/* tb/ipod_player_tb.sv */
`timescale 1ns/1ps

module ipod_player_tb;

  logic                          CLK_50M;
  logic                          rst;
  logic [7:0]                    kbd_ascii;
  logic                          kbd_valid;
  logic                          speed_up;
  logic                          speed_down;
  logic                          speed_reset;
  ipod_pkg::flash_req_t          flash_req;
  ipod_pkg::flash_rsp_t          flash_rsp;
  logic [ipod_pkg::sample_w-1:0] sample;
  logic                          sample_valid;
  logic [ipod_pkg::rate_w-1:0]   rate_count;
  ipod_pkg::player_ctrl_t        ctrl;

  int sample_count;
  int sample_errors;
  int spacing_errors;
  int rate_errors;
  int protocol_errors;
  int ctrl_errors = 0;
  int cycles = 0;
  int seen;

  // Flash model state
  logic [31:0]                       rng;
  int                                wait_run;
  int                                lat_left;
  logic                              data_pending;
  logic [ipod_pkg::flash_addr_w-1:0] data_addr;
  logic                              wr_next;
  logic                              rdv_next;

  tb_clock_gen clk0 (
    .CLK_50M (CLK_50M),
    .rst     (rst)
  );

  ipod_player_top dut0 (
    .CLK_50M      (CLK_50M),
    .rst          (rst),
    .kbd_ascii    (kbd_ascii),
    .kbd_valid    (kbd_valid),
    .speed_up     (speed_up),
    .speed_down   (speed_down),
    .speed_reset  (speed_reset),
    .flash_req    (flash_req),
    .flash_rsp    (flash_rsp),
    .sample       (sample),
    .sample_valid (sample_valid),
    .rate_count   (rate_count),
    .ctrl         (ctrl)
  );

  ipod_checker check0 (
    .CLK_50M         (CLK_50M),
    .rst             (rst),
    .kbd_ascii       (kbd_ascii),
    .kbd_valid       (kbd_valid),
    .speed_up        (speed_up),
    .speed_down      (speed_down),
    .speed_reset     (speed_reset),
    .sample          (sample),
    .sample_valid    (sample_valid),
    .rate_count      (rate_count),
    .flash_req       (flash_req),
    .flash_rsp       (flash_rsp),
    .sample_count    (sample_count),
    .sample_errors   (sample_errors),
    .spacing_errors  (spacing_errors),
    .rate_errors     (rate_errors),
    .protocol_errors (protocol_errors)
  );

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    begin
      x = s;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
    end
  endfunction

  function automatic logic [31:0] image_word(input logic [ipod_pkg::flash_addr_w-1:0] a);
    begin
      return {~a[15:0], a[15:0]};
    end
  endfunction

  // ====================
  // Flash model
  // ====================
  initial
  begin
    rng          = 32'hb5f3;
    wait_run     = 0;
    lat_left     = 0;
    data_pending = 1'b0;
    data_addr    = '0;
    flash_rsp    = '0;
  end

  always @(posedge CLK_50M)
  begin
    rdv_next = 1'b0;
    if (data_pending)
    begin
      lat_left = lat_left - 1;
      if (lat_left == 0)
      begin
        rdv_next     = 1'b1;
        data_pending = 1'b0;
      end
    end
    if (flash_req.read && !flash_rsp.waitrequest)
    begin
      data_addr    = flash_req.address;
      rng          = xorshift32(rng);
      lat_left     = 1 + int'(rng[2:0]);  // 1 to 8 cycles
      data_pending = 1'b1;
    end
    rng      = xorshift32(rng);
    wr_next  = (rng[1:0] == 2'b00) && (wait_run < 3);  // Bursts of at most 3
    wait_run = wr_next ? wait_run + 1 : 0;
    #2;
    flash_rsp.waitrequest   = wr_next;
    flash_rsp.readdatavalid = rdv_next;
    flash_rsp.readdata      = rdv_next ? image_word(data_addr) : '0;
  end

  // ====================
  // Stimulus helpers
  // ====================
  task automatic send_key(input logic [7:0] ch);
    begin
      @(posedge CLK_50M);
      #2;
      kbd_ascii = ch;
      kbd_valid = 1'b1;
      @(posedge CLK_50M);
      #2;
      kbd_valid = 1'b0;
    end
  endtask

  // 0 up, 1 down, 2 back to default
  task automatic pulse_speed(input int kind);
    begin
      @(posedge CLK_50M);
      #2;
      speed_up    = (kind == 0);
      speed_down  = (kind == 1);
      speed_reset = (kind == 2);
      @(posedge CLK_50M);
      #2;
      speed_up    = 1'b0;
      speed_down  = 1'b0;
      speed_reset = 1'b0;
    end
  endtask

  task automatic wait_samples(input int n);
    int target;
    begin
      target = sample_count + n;
      while (sample_count < target)
        @(posedge CLK_50M);
    end
  endtask

  task automatic check_equal(input string name, input int expected, input int actual);
    begin
      if (expected != actual)
      begin
        $display("[FAIL] t=%0t %s expected %0d got %0d", $time, name, expected, actual);
        ctrl_errors = ctrl_errors + 1;
      end
    end
  endtask

  // Whole sequence runs near 65k cycles, so this leaves about three times that
  always @(posedge CLK_50M)
  begin
    cycles = cycles + 1;
    if (cycles >= 200000)
    begin
      $display("Timeout: test sequence still running after %0d cycles", cycles);
      $display("Something failed");
      $finish;
    end
  end

  // ====================
  // Test sequence
  // ====================
  initial
  begin
    kbd_ascii   = 8'h00;
    kbd_valid   = 1'b0;
    speed_up    = 1'b0;
    speed_down  = 1'b0;
    speed_reset = 1'b0;
    @(negedge rst);

    // Idle after reset
    repeat (2 * int'(ipod_pkg::rate_default)) @(posedge CLK_50M);
    check_equal("sample_count", 0, sample_count);
    check_equal("rate_count", int'(ipod_pkg::rate_default), int'(rate_count));
    check_equal("ctrl.playing", 0, int'(ctrl.playing));
    check_equal("ctrl.forward", 1, int'(ctrl.forward));
    check_equal("ctrl.restart", 0, int'(ctrl.restart));

    send_key(ipod_pkg::char_play);
    check_equal("ctrl.playing", 1, int'(ctrl.playing));
    wait_samples(8);

    // Pause holds the position
    send_key(ipod_pkg::char_pause);
    repeat (3) @(posedge CLK_50M);  // A tick from just before the pause may still land
    seen = sample_count;
    repeat (3 * int'(ipod_pkg::rate_default)) @(posedge CLK_50M);
    if (sample_count != seen)
    begin
      $display("Samples kept coming while the player was paused");
      ctrl_errors = ctrl_errors + 1;
    end
    send_key(ipod_pkg::char_play);
    wait_samples(4);

    send_key(ipod_pkg::char_backward);
    check_equal("ctrl.forward", 0, int'(ctrl.forward));
    send_key(ipod_pkg::char_restart);
    wait_samples(5);  // Walks down from the top word
    send_key(ipod_pkg::char_forward);
    send_key(ipod_pkg::char_restart);
    wait_samples(4);

    // Speed range and clamping
    repeat (40) pulse_speed(0);
    check_equal("rate_count", int'(ipod_pkg::rate_min), int'(rate_count));
    wait_samples(6);
    repeat (130) pulse_speed(1);
    check_equal("rate_count", int'(ipod_pkg::rate_max), int'(rate_count));
    wait_samples(3);
    pulse_speed(2);
    check_equal("rate_count", int'(ipod_pkg::rate_default), int'(rate_count));
    wait_samples(3);

    // Longer run under flash back-pressure
    wait_samples(16);

    $display("Errors: sample %0d, spacing %0d, rate %0d, flash %0d, control %0d",
             sample_errors, spacing_errors, rate_errors, protocol_errors, ctrl_errors);
    if (sample_errors + spacing_errors + rate_errors + protocol_errors + ctrl_errors == 0)
      $display("Everything OK");
    else
      $display("Something failed");
    $finish;
  end

endmodule

/* filelist.f */
design/ipod_pkg.sv
design/key_command_decoder.sv
design/rate_controller.sv
design/flash_word_reader.sv
design/sample_sequencer.sv
design/ipod_player_top.sv
tb/tb_clock_gen.sv
tb/ipod_checker.sv
tb/ipod_player_tb.sv

/* Bender.yml */
package:
  name: ipod_player

sources:
  - files:
      - design/ipod_pkg.sv
      - design/key_command_decoder.sv
      - design/rate_controller.sv
      - design/flash_word_reader.sv
      - design/sample_sequencer.sv
      - design/ipod_player_top.sv
  - target: test
    files:
      - tb/tb_clock_gen.sv
      - tb/ipod_checker.sv
      - tb/ipod_player_tb.sv
